/* all.f */
+incdir+design
design/dbg_pkg.sv
design/dbg_ppb_decode.sv
design/dbg_wp_comparator.sv
design/dbg_dwt.sv
design/dbg_halt_ctrl.sv
design/dbg_top.sv
dv/dbg_properties.sv
dv/dbg_tb.sv

/* design/dbg_dwt.sv */
// ----------------------------
// Data watchpoint unit
// Comparators, PCSR, CTRL and read data
// ----------------------------
`timescale 1ns/1ps

module dbg_dwt #(
   parameter int NUM_WPT = 2     // 1 or 2
) (
   input  logic              dclk,
   input  logic              dbg_reset_n,
   input  logic              i_hready,
   input  logic              i_trans,     // Core data transaction
   input  logic [31:0]       i_addr,
   input  logic              i_write,
   input  dbg_pkg::ls_size_e i_ls_size,
   input  logic              i_ia_ok,     // IAEX valid for sampling
   input  logic [30:0]       i_iaex,      // Halfword instruction address
   input  logic              i_pipefull,
   input  logic              i_halted,
   input  logic              i_dwt_en,
   input  dbg_pkg::dwt_sel_t i_sel,
   input  logic              i_ppb_write,
   input  logic [31:0]       i_wdata,
   output logic              o_event,
   output logic [31:0]       o_rdata
);

   logic              rtrans;
   logic              wtrans;
   logic [31:0]       pc;
   logic [1:0]        sel_comp;
   logic [1:0]        sel_mask;
   logic [1:0]        sel_func;
   logic [NUM_WPT-1:0] match;
   logic [31:0]       comp_rdata [NUM_WPT];
   logic              pcsr_ok;
   logic [31:0]       pcsr;
   logic [31:0]       ctrl;

   // ----------------------------
   // Shared comparator inputs
   // ----------------------------

   assign rtrans = i_trans & ~i_write;
   assign wtrans = i_trans &  i_write;
   assign pc     = {i_iaex, 1'b0};

   // Per comparator selects, index is comparator number
   assign sel_comp = {i_sel.comp1, i_sel.comp0};
   assign sel_mask = {i_sel.mask1, i_sel.mask0};
   assign sel_func = {i_sel.func1, i_sel.func0};

   for (genvar g = 0; g < NUM_WPT; g++) begin : gen_wpt
      dbg_wp_comparator u_comp (
         .dclk        (dclk),
         .dbg_reset_n (dbg_reset_n),
         .i_en        (i_dwt_en),
         .i_hready    (i_hready),
         .i_rtrans    (rtrans),
         .i_wtrans    (wtrans),
         .i_execute   (i_pipefull),   // Executing instr is a PC transaction
         .i_addr      (i_addr),
         .i_size      (i_ls_size),
         .i_pc        (pc),
         .i_sel_comp  (sel_comp[g]),
         .i_sel_mask  (sel_mask[g]),
         .i_sel_func  (sel_func[g]),
         .i_write     (i_ppb_write),
         .i_wdata     (i_wdata),
         .o_match     (match[g]),
         .o_rdata     (comp_rdata[g])
      );
   end

   assign o_event = |match;   // Any comparator

   // ----------------------------
   // PCSR and CTRL
   // ----------------------------

   // All ones when halted or in exception space
   assign pcsr_ok = i_ia_ok & ~i_halted & (i_iaex[30:27] != 4'hF);
   assign pcsr    = pc | {32{~pcsr_ok}};
   assign ctrl    = {4'(NUM_WPT), 28'b0};   // NUMCOMP in 31:28

   // Read mux, selects are one-hot
   always_comb begin
      o_rdata = ({32{i_sel.ctrl}} & ctrl) | ({32{i_sel.pcsr}} & pcsr);
      for (int i = 0; i < NUM_WPT; i++) begin
         o_rdata = o_rdata | comp_rdata[i];
      end
   end

endmodule

/* design/dbg_halt_ctrl.sv */
// ----------------------------
// Halt controller
// DHCSR debug enable and halted state
// ----------------------------
`timescale 1ns/1ps

module dbg_halt_ctrl (
   input  logic        dclk,
   input  logic        dbg_reset_n,
   input  logic        i_sel,       // DHCSR select
   input  logic        i_write,
   input  logic [31:0] i_wdata,
   input  logic        i_event,     // Watchpoint event
   input  logic        i_hready,
   output logic        o_dwt_en,
   output logic        o_halted,
   output logic [31:0] o_rdata
);

   logic debugen_q;  // C_DEBUGEN
   logic halted_q;   // S_HALT
   logic dhcsr_wr;
   logic evt_halt;

   assign dhcsr_wr = i_sel & i_write;
   assign evt_halt = i_event & i_hready & debugen_q;   // Blocked by stall

   // ----------------------------
   // State
   // ----------------------------

   always_ff @(posedge dclk or negedge dbg_reset_n) begin
      if (!dbg_reset_n) begin
         debugen_q <= 1'b0;
         halted_q  <= 1'b0;
      end else begin
         if (dhcsr_wr) begin
            debugen_q <= i_wdata[0];
            halted_q  <= i_wdata[1];   // C_HALT sets or releases
         end else if (evt_halt) begin
            halted_q  <= 1'b1;
         end
      end
   end

   assign o_dwt_en = debugen_q;
   assign o_halted = halted_q;

   // ----------------------------
   // DHCSR read
   // ----------------------------

   always_comb begin
      o_rdata = '0;
      if (i_sel) begin
         o_rdata[17] = halted_q;   // S_HALT
         o_rdata[1]  = halted_q;   // C_HALT
         o_rdata[0]  = debugen_q;  // C_DEBUGEN
      end
   end

endmodule

/* design/dbg_params.svh */
// ----------------------------
// Debug subsystem parameters
// Comparator count and register port word offsets
// ----------------------------
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// Comparators present, 1 or 2
`define DBG_NUM_WPT 2

// Word offsets on i_ppb_addr[11:2]
`define DBG_ADDR_CTRL   10'h000 // Byte 0x000
`define DBG_ADDR_PCSR   10'h007 // Byte 0x01C
`define DBG_ADDR_COMP0  10'h008 // Byte 0x020
`define DBG_ADDR_MASK0  10'h009 // Byte 0x024
`define DBG_ADDR_FUNC0  10'h00A // Byte 0x028
`define DBG_ADDR_COMP1  10'h00C // Byte 0x030
`define DBG_ADDR_MASK1  10'h00D // Byte 0x034
`define DBG_ADDR_FUNC1  10'h00E // Byte 0x038
`define DBG_ADDR_DHCSR  10'h040 // Byte 0x100

`endif

/* design/dbg_pkg.sv */
// ----------------------------
// Debug subsystem types
// Watchpoint function, access size, DWT selects
// ----------------------------
package dbg_pkg;

   // Bit 2 enable, bit 1 write, bit 0 read
   typedef enum logic [2:0] {
      WP_OFF   = 3'b000,  // Any value with bit 2 clear is off
      WP_PC    = 3'b100,  // PC match
      WP_READ  = 3'b101,
      WP_WRITE = 3'b110,
      WP_RW    = 3'b111
   } wp_func_e;

   // Core data access size
   typedef enum logic [1:0] {
      LS_BYTE = 2'b00,
      LS_HALF = 2'b01,
      LS_WORD = 2'b10
   } ls_size_e;

   // One-hot DWT register selects, CTRL in the top bit
   typedef struct packed {
      logic ctrl;
      logic pcsr;
      logic comp0;
      logic mask0;
      logic func0;
      logic comp1;
      logic mask1;
      logic func1;
   } dwt_sel_t;

endpackage

/* design/dbg_ppb_decode.sv */
// ----------------------------
// Register port decoder
// Turns the word offset into one-hot DWT and DHCSR selects
// ----------------------------
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_ppb_decode (
   input  logic              dclk,
   input  logic              dbg_reset_n,
   input  logic              i_ppb_sel,    // Valid access this cycle
   input  logic              i_ppb_write,  // Write not read
   input  logic [11:2]       i_ppb_addr,   // Word offset
   output dbg_pkg::dwt_sel_t o_dwt_sel,
   output logic              o_dhcsr_sel,
   output logic              o_ppb_write   // Shared write strobe
);

   // Comparator 1 decode only when it exists
   localparam bit HAS_WPT1 = (`DBG_NUM_WPT > 1);

   logic port_en_q;  // Port open once out of reset
   logic acc;        // Qualified access

   // ----------------------------
   // Port enable
   // ----------------------------

   // Holds off accesses for the first edge after reset so that every
   // register block leaves reset before it sees a strobe
   always_ff @(posedge dclk or negedge dbg_reset_n) begin
      if (!dbg_reset_n) begin
         port_en_q <= 1'b0;
      end else begin
         port_en_q <= 1'b1;
      end
   end

   assign acc = i_ppb_sel & port_en_q;

   // ----------------------------
   // Address match
   // ----------------------------

   always_comb begin
      o_dwt_sel.ctrl  = acc & (i_ppb_addr == `DBG_ADDR_CTRL);
      o_dwt_sel.pcsr  = acc & (i_ppb_addr == `DBG_ADDR_PCSR);
      o_dwt_sel.comp0 = acc & (i_ppb_addr == `DBG_ADDR_COMP0);
      o_dwt_sel.mask0 = acc & (i_ppb_addr == `DBG_ADDR_MASK0);
      o_dwt_sel.func0 = acc & (i_ppb_addr == `DBG_ADDR_FUNC0);
      // Second comparator, absent reads as unmapped
      o_dwt_sel.comp1 = HAS_WPT1 & acc & (i_ppb_addr == `DBG_ADDR_COMP1);
      o_dwt_sel.mask1 = HAS_WPT1 & acc & (i_ppb_addr == `DBG_ADDR_MASK1);
      o_dwt_sel.func1 = HAS_WPT1 & acc & (i_ppb_addr == `DBG_ADDR_FUNC1);
   end

   assign o_dhcsr_sel = acc & (i_ppb_addr == `DBG_ADDR_DHCSR);

   // Direction only, consumers form their own enables
   assign o_ppb_write = acc & i_ppb_write;

endmodule

/* design/dbg_top.sv */
// ----------------------------
// Debug watchpoint subsystem
// Register decode, watchpoint unit, halt control
// ----------------------------
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_top (
   input  logic              dclk,
   input  logic              dbg_reset_n,
   // Register port
   input  logic              i_ppb_sel,
   input  logic              i_ppb_write,
   input  logic [11:2]       i_ppb_addr,
   input  logic [31:0]       i_ppb_wdata,
   // Core side
   input  logic              i_trans,
   input  logic [31:0]       i_addr,
   input  logic              i_write,
   input  dbg_pkg::ls_size_e i_ls_size,
   input  logic              i_hready,
   input  logic              i_pipefull,
   input  logic [30:0]       i_iaex,
   input  logic              i_ia_ok,
   output logic [31:0]       o_ppb_rdata,
   output logic              o_dwt_event,
   output logic              o_halted
);

   import dbg_pkg::*;

   dwt_sel_t    dwt_sel;
   logic        dhcsr_sel;
   logic        ppb_write;
   logic        dwt_en;
   logic [31:0] dwt_rdata;
   logic [31:0] dhcsr_rdata;

   dbg_ppb_decode u_decode (
      .dclk        (dclk),
      .dbg_reset_n (dbg_reset_n),
      .i_ppb_sel   (i_ppb_sel),
      .i_ppb_write (i_ppb_write),
      .i_ppb_addr  (i_ppb_addr),
      .o_dwt_sel   (dwt_sel),
      .o_dhcsr_sel (dhcsr_sel),
      .o_ppb_write (ppb_write)
   );

   dbg_dwt #(.NUM_WPT(`DBG_NUM_WPT)) u_dwt (
      .dclk        (dclk),
      .dbg_reset_n (dbg_reset_n),
      .i_hready    (i_hready),
      .i_trans     (i_trans),
      .i_addr      (i_addr),
      .i_write     (i_write),
      .i_ls_size   (i_ls_size),
      .i_ia_ok     (i_ia_ok),
      .i_iaex      (i_iaex),
      .i_pipefull  (i_pipefull),
      .i_halted    (o_halted),     // Halt feeds PCSR
      .i_dwt_en    (dwt_en),
      .i_sel       (dwt_sel),
      .i_ppb_write (ppb_write),
      .i_wdata     (i_ppb_wdata),
      .o_event     (o_dwt_event),
      .o_rdata     (dwt_rdata)
   );

   dbg_halt_ctrl u_halt (
      .dclk        (dclk),
      .dbg_reset_n (dbg_reset_n),
      .i_sel       (dhcsr_sel),
      .i_write     (ppb_write),
      .i_wdata     (i_ppb_wdata),
      .i_event     (o_dwt_event),
      .i_hready    (i_hready),
      .o_dwt_en    (dwt_en),
      .o_halted    (o_halted),
      .o_rdata     (dhcsr_rdata)
   );

   // Unselected sources return zero
   assign o_ppb_rdata = dwt_rdata | dhcsr_rdata;

endmodule

/* design/dbg_wp_comparator.sv */
// ----------------------------
// Watchpoint comparator
// COMP, MASK, FUNC registers, address/PC match and MATCHED
// ----------------------------
`timescale 1ns/1ps

module dbg_wp_comparator (
   input  logic              dclk,
   input  logic              dbg_reset_n,
   input  logic              i_en,        // Unit enable (C_DEBUGEN)
   input  logic              i_hready,    // Core advances
   input  logic              i_rtrans,    // Data read
   input  logic              i_wtrans,    // Data write
   input  logic              i_execute,   // Instruction executing
   input  logic [31:0]       i_addr,
   input  dbg_pkg::ls_size_e i_size,
   input  logic [31:0]       i_pc,
   input  logic              i_sel_comp,
   input  logic              i_sel_mask,
   input  logic              i_sel_func,
   input  logic              i_write,     // Register write strobe
   input  logic [31:0]       i_wdata,
   output logic              o_match,
   output logic [31:0]       o_rdata
);

   import dbg_pkg::*;

   logic        comp_wr;
   logic        mask_wr;
   logic        func_wr;
   logic        func_rd;
   logic        mat_en;

   logic [31:0] comp_q;     // COMP
   logic [4:0]  mask_q;     // MASK
   wp_func_e    func_q;     // FUNCTION
   logic        matched_q;  // MATCHED

   logic        off;
   logic [4:0]  mask_eff;
   logic [31:0] mask_32;
   logic        pcmode;
   logic        cmp_1;
   logic        cmp_0;
   logic [31:0] test_val;
   logic [31:0] value;
   logic        addr_hit;
   logic        kind_ok;

   // ----------------------------
   // Register enables
   // ----------------------------

   assign comp_wr = i_sel_comp & i_write;
   assign mask_wr = i_sel_mask & i_write;
   assign func_wr = i_sel_func & i_write;
   assign func_rd = i_sel_func & ~i_write;   // Clear-on-read trigger
   assign mat_en  = func_rd | (o_match & i_hready);

   always_ff @(posedge dclk or negedge dbg_reset_n) begin
      if (!dbg_reset_n) begin
         comp_q    <= '1;
         mask_q    <= '1;
         func_q    <= WP_OFF;
         matched_q <= 1'b0;
      end else begin
         if (comp_wr) comp_q <= i_wdata;
         if (mask_wr) mask_q <= i_wdata[4:0];            // 5-bit mask
         if (func_wr) func_q <= wp_func_e'(i_wdata[2:0]);
         if (mat_en)  matched_q <= o_match;              // Clears when no hit
      end
   end

   // ----------------------------
   // Match logic
   // ----------------------------

   assign off      = ~func_q[2] | ~i_en;
   assign mask_eff = mask_q | {5{off}};        // Idle when off
   assign mask_32  = 32'hFFFF_FFFF << mask_eff;
   assign pcmode   = (func_q[1:0] == 2'b00);   // WP_PC when on
   assign cmp_1    = pcmode | (i_size != LS_WORD);
   assign cmp_0    = (i_size == LS_BYTE);
   assign test_val = {comp_q[31:2], comp_q[1] & cmp_1, comp_q[0] & cmp_0};
   assign value    = pcmode ? i_pc : i_addr;
   assign addr_hit = ((value & mask_32) == test_val);

   // Access kind against function
   assign kind_ok = (func_q[0] & i_rtrans) |
                    (func_q[1] & i_wtrans) |
                    (pcmode & i_execute);

   assign o_match = kind_ok & addr_hit & ~off;

   // ----------------------------
   // Read data
   // ----------------------------

   always_comb begin
      o_rdata = '0;
      if (i_sel_comp) o_rdata = comp_q;
      if (i_sel_mask) o_rdata = {27'b0, mask_q};
      if (i_sel_func) o_rdata = {7'b0, matched_q, 21'b0, func_q}; // MATCHED bit 24
   end

endmodule

/* dv/dbg_properties.sv */
// ----------------------------
// Register decoder assertions
// Select one-hotness and strobe sanity
// ----------------------------
`timescale 1ns/1ps

module dbg_properties (
   input logic              dclk,
   input logic              dbg_reset_n,
   input logic              i_ppb_sel,
   input dbg_pkg::dwt_sel_t o_dwt_sel,
   input logic              o_dhcsr_sel
);

   logic [8:0] all_sel;   // DWT selects plus DHCSR

   assign all_sel = {o_dwt_sel, o_dhcsr_sel};

   // At most one register per access
   a_onehot: assert property (@(posedge dclk) disable iff (!dbg_reset_n)
      $onehot0(all_sel)) else $error("register selects not one-hot");

   // No select without a port access
   a_gated: assert property (@(posedge dclk) disable iff (!dbg_reset_n)
      !i_ppb_sel |-> (all_sel == '0)) else $error("select without i_ppb_sel");

   a_known: assert property (@(posedge dclk) disable iff (!dbg_reset_n)
      !$isunknown(all_sel)) else $error("unknown register select");

endmodule

bind dbg_ppb_decode dbg_properties props_i (
   .dclk        (dclk),
   .dbg_reset_n (dbg_reset_n),
   .i_ppb_sel   (i_ppb_sel),
   .o_dwt_sel   (o_dwt_sel),
   .o_dhcsr_sel (o_dhcsr_sel)
);

/* dv/dbg_tb.sv */
// ----------------------------
// Debug watchpoint testbench
// Register tasks, reference model, event checker, timeout
// ----------------------------
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_tb;

   import dbg_pkg::*;

   localparam int LIMIT = 4000;   // Cap well above the roughly 400 cycles of tests

   logic        dclk = 0;
   logic        dbg_reset_n = 0;
   // Register port
   logic        ppb_sel = 0;
   logic        ppb_write = 0;
   logic [9:0]  ppb_addr = '0;
   logic [31:0] ppb_wdata = '0;
   // Core side
   logic        trans = 0;
   logic        write = 0;
   logic        hready = 1;
   logic        pipefull = 0;
   logic        ia_ok = 0;
   logic [31:0] addr = '0;
   logic [30:0] iaex = '0;
   logic [1:0]  size = 2'b10;   // Word
   // DUT outputs
   logic [31:0] rdata;
   logic        evt;
   logic        halted;
   logic [31:0] rng = 32'd22;   // xorshift state
   logic        check_on = 0;
   int          cycles = 0;

   // Model state
   logic [31:0] m_comp [2];
   logic [4:0]  m_mask [2];
   logic [2:0]  m_func [2];
   logic        m_den;

   dbg_top dut_i (
      .dclk        (dclk),
      .dbg_reset_n (dbg_reset_n),
      .i_ppb_sel   (ppb_sel),
      .i_ppb_write (ppb_write),
      .i_ppb_addr  (ppb_addr),
      .i_ppb_wdata (ppb_wdata),
      .i_trans     (trans),
      .i_addr      (addr),
      .i_write     (write),
      .i_ls_size   (ls_size_e'(size)),
      .i_hready    (hready),
      .i_pipefull  (pipefull),
      .i_iaex      (iaex),
      .i_ia_ok     (ia_ok),
      .o_ppb_rdata (rdata),
      .o_dwt_event (evt),
      .o_halted    (halted)
   );

   always #2 dclk = ~dclk;   // 4 ns period

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Expected hit of one comparator from current inputs
   function automatic logic ref_hit(input int w);
      logic [31:0] v, mk, cv;
      logic pcm, kind;
      if (!m_func[w][2] || !m_den) return 1'b0;    // Off or unit disabled
      pcm = (m_func[w][1:0] == 2'b00);
      v   = pcm ? {iaex, 1'b0} : addr;
      mk  = 32'hFFFF_FFFF << m_mask[w];
      cv  = m_comp[w];
      if (!pcm && size == 2'b10) cv[1] = 1'b0;    // Word access drops bit 1
      if (size != 2'b00) cv[0] = 1'b0;            // Bit 0 only for bytes
      kind = pcm ? pipefull : (trans & (write ? m_func[w][1] : m_func[w][0]));
      return kind && ((v & mk) == cv);
   endfunction

   function automatic logic [31:0] ref_pcsr(input logic hlt);
      if (ia_ok && !hlt && iaex[30:27] != 4'hF) return {iaex, 1'b0};
      return 32'hFFFF_FFFF;    // Halted or exception space
   endfunction

   task automatic check(input string name, input logic [31:0] got, exp);
      if (got !== exp) begin
         $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // ----------------------------
   // Bus and core cycles
   // ----------------------------
   task automatic port_cycle(input logic wr, input logic [9:0] a, input logic [31:0] d);
      @(posedge dclk);
      #1;
      ppb_sel   = 1;
      ppb_write = wr;
      ppb_addr  = a;
      ppb_wdata = d;
      trans     = 0;   // Core idle
      pipefull  = 0;
      hready    = 1;
   endtask

   task automatic reg_write(input logic [9:0] a, input logic [31:0] d);
      port_cycle(1'b1, a, d);
      for (int w = 0; w < 2; w++) begin
         if (a == `DBG_ADDR_COMP0 + 4 * w) m_comp[w] = d;
         if (a == `DBG_ADDR_MASK0 + 4 * w) m_mask[w] = d[4:0];
         if (a == `DBG_ADDR_FUNC0 + 4 * w) m_func[w] = d[2:0];
      end
      if (a == `DBG_ADDR_DHCSR) m_den = d[0];
   endtask

   task automatic reg_read(input string name, input logic [9:0] a, input logic [31:0] exp);
      port_cycle(1'b0, a, '0);
      #2;    // Combinational read settles before the edge
      check(name, rdata, exp);
   endtask

   task automatic core_cycle(input logic t, wr, rdy, pf, input logic [1:0] sz,
                             input logic [31:0] ad, input logic [30:0] ia);
      @(posedge dclk);
      #1;
      ppb_sel   = 0;
      ppb_write = 0;
      trans     = t;
      write     = wr;
      hready    = rdy;
      pipefull  = pf;
      size      = sz;
      addr      = ad;
      iaex      = ia;
   endtask

   // Event compared every cycle mid-period
   always @(negedge dclk) begin
      if (check_on) check("o_dwt_event", {31'b0, evt}, {31'b0, ref_hit(0) | ref_hit(1)});
   end

   always @(posedge dclk) begin
      cycles = cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", LIMIT);
         $display("Test failed");
         $fatal(1);
      end
   end

   initial begin
      logic [31:0] r, c, f;
      int w;
      for (int i = 0; i < 2; i++) begin
         m_comp[i] = '1;
         m_mask[i] = '1;
         m_func[i] = '0;
      end
      m_den = 0;
      repeat (3) @(posedge dclk);
      #1 dbg_reset_n = 1;
      check_on = 1;
      @(posedge dclk);    // Decoder opens the port

      // ---------- Reset values and map
      reg_read("CTRL", `DBG_ADDR_CTRL, 32'h2000_0000);
      reg_read("COMP0", `DBG_ADDR_COMP0, 32'hFFFF_FFFF);
      reg_read("COMP1", `DBG_ADDR_COMP1, 32'hFFFF_FFFF);
      reg_read("MASK0", `DBG_ADDR_MASK0, 32'h1F);
      reg_read("MASK1", `DBG_ADDR_MASK1, 32'h1F);
      reg_read("FUNC0", `DBG_ADDR_FUNC0, 0);
      reg_read("FUNC1", `DBG_ADDR_FUNC1, 0);
      reg_read("DHCSR", `DBG_ADDR_DHCSR, 0);
      reg_read("UNMAPPED", 10'h001, 0);
      reg_read("UNMAPPED", 10'h0FF, 0);
      check("o_halted", {31'b0, halted}, 0);

      // ---------- Write and readback
      for (int i = 0; i < 2; i++) begin
         c = next_rand();
         r = next_rand();
         f = next_rand();
         reg_write(`DBG_ADDR_COMP0 + 4 * i, c);
         reg_write(`DBG_ADDR_MASK0 + 4 * i, r);
         reg_write(`DBG_ADDR_FUNC0 + 4 * i, f);
         reg_read("COMP", `DBG_ADDR_COMP0 + 4 * i, c);
         reg_read("MASK", `DBG_ADDR_MASK0 + 4 * i, r & 32'h1F);
         reg_read("FUNC", `DBG_ADDR_FUNC0 + 4 * i, f & 32'h7);
      end

      // ---------- Random data watchpoints
      for (int n = 0; n < 200; n++) begin
         if (n % 10 == 0) begin
            for (int i = 0; i < 2; i++) begin
               reg_write(`DBG_ADDR_COMP0 + 4 * i, next_rand());
               reg_write(`DBG_ADDR_MASK0 + 4 * i, next_rand() % 8);
               reg_write(`DBG_ADDR_FUNC0 + 4 * i, next_rand());
            end
            reg_write(`DBG_ADDR_DHCSR, {31'b0, (next_rand() % 4) != 0});  // Mostly on
         end
         w = next_rand() % 2;
         r = next_rand();
         c = r[0] ? (m_comp[w] ^ (next_rand() & ~(32'hFFFF_FFFF << m_mask[w]))) : next_rand();
         core_cycle((r[3:2] != 0), r[4], 1'b1, r[5], 2'(r[9:8] % 3), c,
                    r[6] ? m_comp[w][31:1] : next_rand());
      end

      // ---------- MATCHED clear-on-read
      reg_write(`DBG_ADDR_DHCSR, 1);
      reg_write(`DBG_ADDR_FUNC1, 0);
      reg_write(`DBG_ADDR_COMP0, 32'h1000);
      reg_write(`DBG_ADDR_MASK0, 0);
      reg_write(`DBG_ADDR_FUNC0, 7);
      port_cycle(1'b0, `DBG_ADDR_FUNC0, '0);    // Flush MATCHED left by random hits
      reg_read("FUNC0", `DBG_ADDR_FUNC0, 7);
      core_cycle(1, 0, 1, 0, 2'b10, 32'h1000, 0);
      reg_read("FUNC0", `DBG_ADDR_FUNC0, 32'h0100_0007);
      check("o_halted", {31'b0, halted}, 1);
      reg_read("DHCSR", `DBG_ADDR_DHCSR, 32'h0002_0003);   // S_HALT from the event
      reg_read("FUNC0", `DBG_ADDR_FUNC0, 7);
      core_cycle(1, 1, 0, 0, 2'b10, 32'h1000, 0);   // Stalled hit
      reg_read("FUNC0", `DBG_ADDR_FUNC0, 7);
      reg_write(`DBG_ADDR_DHCSR, 1);

      // ---------- PC watchpoint and PCSR
      reg_write(`DBG_ADDR_FUNC0, 0);
      reg_write(`DBG_ADDR_COMP1, 32'h2468);
      reg_write(`DBG_ADDR_MASK1, 0);
      reg_write(`DBG_ADDR_FUNC1, 4);
      core_cycle(0, 0, 1, 1, 2'b10, 0, 31'h1234);   // Executes 0x2468
      @(negedge dclk);
      check("o_dwt_event", {31'b0, evt}, 1);
      reg_write(`DBG_ADDR_DHCSR, 1);
      ia_ok = 1;
      iaex = next_rand() & 31'h3FFF_FFFF;
      reg_read("PCSR", `DBG_ADDR_PCSR, ref_pcsr(0));
      iaex = 31'h7C00_0010;
      reg_read("PCSR", `DBG_ADDR_PCSR, ref_pcsr(0));   // Exception space
      iaex = 31'h0000_0400;
      ia_ok = 0;
      reg_read("PCSR", `DBG_ADDR_PCSR, ref_pcsr(0));
      ia_ok = 1;

      // ---------- Halting by request
      reg_write(`DBG_ADDR_DHCSR, 3);
      reg_read("DHCSR", `DBG_ADDR_DHCSR, 32'h0002_0003);
      check("o_halted", {31'b0, halted}, 1);
      reg_read("PCSR", `DBG_ADDR_PCSR, ref_pcsr(1));
      reg_write(`DBG_ADDR_DHCSR, 1);
      reg_read("DHCSR", `DBG_ADDR_DHCSR, 32'h1);
      check("o_halted", {31'b0, halted}, 0);
      @(posedge dclk);
      #1 ppb_sel = 0;

      $display("Test passed");
      $finish;
   end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the debug watchpoint testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing -Wall -Wno-fatal \
   -f all.f --top-module dbg_tb -o dbg_sim

# The testbench stops with a nonzero status on failure, the log decides
./obj_dir/dbg_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
   exit 1
fi
grep -q "Test passed" sim.log
